/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // word-addressed memories inside the core
    localparam int imem_depth  = 256;
    localparam int dmem_depth  = 256;
    localparam int imem_addr_w = $clog2(imem_depth);
    localparam int dmem_addr_w = $clog2(dmem_depth);

    // addi x0, x0, 0 doubles as the pipeline bubble
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        // register file value read in decode
        fwd_none = 2'b00,
        // result leaving writeback
        fwd_wb   = 2'b01,
        // alu result held in memory stage
        fwd_mem  = 2'b10
    } fwd_sel_e;

endpackage

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    // sources of the instruction in decode
    input  logic [pipe_pkg::reg_addr_w-1:0] rs1_d_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs2_d_i,
    // sources and destination in execute
    input  logic [pipe_pkg::reg_addr_w-1:0] rs1_e_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs2_e_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rd_e_i,
    // older destinations
    input  logic [pipe_pkg::reg_addr_w-1:0] rd_m_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rd_w_i,
    input  logic                            mem_read_e_i,
    input  logic                            reg_wr_en_m_i,
    input  logic                            reg_wr_en_w_i,
    input  logic                            ctrl_taken_e_i,
    output pipe_pkg::fwd_sel_e              forward_a_e_o,
    output pipe_pkg::fwd_sel_e              forward_b_e_o,
    output logic                            stall_o,
    output logic                            flush_o
);
    import pipe_pkg::*;

    logic load_use;

    // memory stage is younger, so it wins when both stages match
    function automatic fwd_sel_e fwd_pick(logic [reg_addr_w-1:0] src);
        fwd_sel_e sel;
        sel = fwd_none;
        if (reg_wr_en_m_i && (rd_m_i != '0) && (rd_m_i == src)) begin
            sel = fwd_mem;
        end else if (reg_wr_en_w_i && (rd_w_i != '0) && (rd_w_i == src)) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a_e_o = fwd_pick(rs1_e_i);
        forward_b_e_o = fwd_pick(rs2_e_i);
    end

    // load data only exists after memory, one bubble lines it up with writeback
    assign load_use = mem_read_e_i && (rd_e_i != '0)
                      && ((rd_e_i == rs1_d_i) || (rd_e_i == rs2_d_i));

    // taken branch or jal discards the two younger instructions
    assign flush_o = ctrl_taken_e_i;
    // stalled instruction is flushed anyway
    assign stall_o = load_use && !ctrl_taken_e_i;

endmodule

`default_nettype wire

/* core/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  logic [pipe_pkg::xlen-1:0]       instr_i,
    output logic [pipe_pkg::reg_addr_w-1:0] rs1_o,
    output logic [pipe_pkg::reg_addr_w-1:0] rs2_o,
    output logic [pipe_pkg::reg_addr_w-1:0] rd_o,
    output logic [pipe_pkg::xlen-1:0]       imm_o,
    output pipe_pkg::alu_op_e               alu_op_o,
    output logic                            alu_src_imm_o,
    output logic                            reg_wr_en_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o,
    output logic                            branch_o,
    output logic                            jump_o
);
    import pipe_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       r_legal;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // add sub and or xor slt only, shifts and sltu are outside the subset
    assign r_legal = ((funct7 == 7'b0000000) && (funct3 inside {3'b000, 3'b010, 3'b100,
                                                                3'b110, 3'b111}))
                     || ((funct7 == 7'b0100000) && (funct3 == 3'b000));

    // unused source fields go to x0 so the hazard unit sees no false match
    assign rs1_o = use_rs1 ? instr_i[19:15] : '0;
    assign rs2_o = use_rs2 ? instr_i[24:20] : '0;

    always_comb begin
        // default is a bubble that writes nothing
        rd_o          = '0;
        imm_o         = '0;
        alu_op_o      = alu_add;
        alu_src_imm_o = 1'b0;
        reg_wr_en_o   = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        branch_o      = 1'b0;
        jump_o        = 1'b0;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        case (opcode)
            opc_op: begin
                if (r_legal) begin
                    rd_o        = instr_i[11:7];
                    reg_wr_en_o = 1'b1;
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    case (funct3)
                        3'b010:  alu_op_o = alu_slt;
                        3'b100:  alu_op_o = alu_xor;
                        3'b110:  alu_op_o = alu_or;
                        3'b111:  alu_op_o = alu_and;
                        // funct7 bit 5 picks sub
                        default: alu_op_o = funct7[5] ? alu_sub : alu_add;
                    endcase
                end
            end
            opc_op_imm: begin
                // addi only
                if (funct3 == 3'b000) begin
                    rd_o          = instr_i[11:7];
                    imm_o         = {{20{instr_i[31]}}, instr_i[31:20]};
                    alu_src_imm_o = 1'b1;
                    reg_wr_en_o   = 1'b1;
                    use_rs1       = 1'b1;
                end
            end
            opc_load: begin
                // lw, address is rs1 plus I immediate
                if (funct3 == 3'b010) begin
                    rd_o          = instr_i[11:7];
                    imm_o         = {{20{instr_i[31]}}, instr_i[31:20]};
                    alu_src_imm_o = 1'b1;
                    reg_wr_en_o   = 1'b1;
                    mem_read_o    = 1'b1;
                    use_rs1       = 1'b1;
                end
            end
            opc_store: begin
                // sw with split S immediate
                if (funct3 == 3'b010) begin
                    imm_o         = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                    alu_src_imm_o = 1'b1;
                    mem_write_o   = 1'b1;
                    use_rs1       = 1'b1;
                    use_rs2       = 1'b1;
                end
            end
            opc_branch: begin
                // beq, compare is done on the forwarded operands
                if (funct3 == 3'b000) begin
                    imm_o    = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
                    branch_o = 1'b1;
                    use_rs1  = 1'b1;
                    use_rs2  = 1'b1;
                end
            end
            opc_jal: begin
                rd_o        = instr_i[11:7];
                imm_o       = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                               instr_i[20], instr_i[30:21], 1'b0};
                reg_wr_en_o = 1'b1;
                jump_o      = 1'b1;
            end
            default: begin
                // unknown opcode keeps the bubble defaults
            end
        endcase
    end

endmodule

`default_nettype wire

/* core/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rs2_i,
    input  logic                            wr_en_i,
    input  logic [pipe_pkg::reg_addr_w-1:0] rd_i,
    input  logic [pipe_pkg::xlen-1:0]       wr_data_i,
    output logic [pipe_pkg::xlen-1:0]       rs1_data_o,
    output logic [pipe_pkg::xlen-1:0]       rs2_data_o
);
    import pipe_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];
    logic            wr_live;

    // x0 is never written, so it reads zero after reset
    assign wr_live = wr_en_i && (rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    // writeback and decode share a cycle, bypass the new value
    assign rs1_data_o = (wr_live && (rd_i == rs1_i)) ? wr_data_i : regs[rs1_i];
    assign rs2_data_o = (wr_live && (rd_i == rs2_i)) ? wr_data_i : regs[rs2_i];

endmodule

`default_nettype wire

/* core/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic [pipe_pkg::xlen-1:0] pc_e_i,
    input  logic [pipe_pkg::xlen-1:0] rs1_data_e_i,
    input  logic [pipe_pkg::xlen-1:0] rs2_data_e_i,
    input  logic [pipe_pkg::xlen-1:0] imm_e_i,
    input  pipe_pkg::alu_op_e         alu_op_e_i,
    input  logic                      alu_src_imm_e_i,
    input  logic                      branch_e_i,
    input  logic                      jump_e_i,
    input  pipe_pkg::fwd_sel_e        forward_a_e_i,
    input  pipe_pkg::fwd_sel_e        forward_b_e_i,
    input  logic [pipe_pkg::xlen-1:0] alu_result_m_i,
    input  logic [pipe_pkg::xlen-1:0] result_w_i,
    output logic [pipe_pkg::xlen-1:0] alu_result_o,
    output logic [pipe_pkg::xlen-1:0] store_data_o,
    output logic                      ctrl_taken_o,
    output logic [pipe_pkg::xlen-1:0] ctrl_target_o
);
    import pipe_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_out;

    function automatic logic [xlen-1:0] fwd_mux(fwd_sel_e sel, logic [xlen-1:0] reg_val,
                                                logic [xlen-1:0] mem_val,
                                                logic [xlen-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a   = fwd_mux(forward_a_e_i, rs1_data_e_i, alu_result_m_i, result_w_i);
    assign rs2_fwd = fwd_mux(forward_b_e_i, rs2_data_e_i, alu_result_m_i, result_w_i);
    // store data must also see forwarded values
    assign store_data_o = rs2_fwd;
    assign src_b = alu_src_imm_e_i ? imm_e_i : rs2_fwd;

    always_comb begin
        case (alu_op_e_i)
            alu_sub: alu_out = src_a - src_b;
            alu_and: alu_out = src_a & src_b;
            alu_or:  alu_out = src_a | src_b;
            alu_xor: alu_out = src_a ^ src_b;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default: alu_out = src_a + src_b;
        endcase
    end

    // jal writes the link address instead
    assign alu_result_o = jump_e_i ? (pc_e_i + xlen'(4)) : alu_out;

    // beq compares the register operands, never the immediate
    assign ctrl_taken_o  = jump_e_i || (branch_e_i && (src_a == rs2_fwd));
    assign ctrl_target_o = pc_e_i + imm_e_i;

endmodule

`default_nettype wire

/* core/pipe_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_core (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             imem_we_i,
    input  logic [pipe_pkg::imem_addr_w-1:0] imem_addr_i,
    input  logic [pipe_pkg::xlen-1:0]        imem_wdata_i,
    output logic                             retire_valid_o,
    output logic [pipe_pkg::reg_addr_w-1:0]  retire_rd_o,
    output logic [pipe_pkg::xlen-1:0]        retire_data_o,
    output logic [pipe_pkg::xlen-1:0]        retire_pc_o
);
    import pipe_pkg::*;

    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] dmem [dmem_depth];

    // fetch and decode
    logic [xlen-1:0]       pc_f;
    logic [xlen-1:0]       instr_f;
    logic [xlen-1:0]       pc_d;
    logic [xlen-1:0]       instr_d;
    logic [reg_addr_w-1:0] rs1_d;
    logic [reg_addr_w-1:0] rs2_d;
    logic [reg_addr_w-1:0] rd_d;
    logic [xlen-1:0]       imm_d;
    logic [xlen-1:0]       rs1_data_d;
    logic [xlen-1:0]       rs2_data_d;
    alu_op_e               alu_sel_d;
    logic alu_src_imm_d, reg_wr_en_d, mem_read_d, mem_write_d, branch_d, jump_d;

    // execute
    logic [xlen-1:0]       pc_e;
    logic [reg_addr_w-1:0] rs1_e;
    logic [reg_addr_w-1:0] rs2_e;
    logic [reg_addr_w-1:0] rd_e;
    logic [xlen-1:0]       imm_e;
    logic [xlen-1:0]       rs1_data_e;
    logic [xlen-1:0]       rs2_data_e;
    logic [xlen-1:0]       alu_result_e;
    logic [xlen-1:0]       store_data_e;
    logic [xlen-1:0]       ctrl_target_e;
    alu_op_e               alu_sel_e;
    logic alu_src_imm_e, reg_wr_en_e, mem_read_e, mem_write_e, branch_e, jump_e;
    logic ctrl_taken_e;

    // memory and writeback
    logic [xlen-1:0]       pc_m;
    logic [reg_addr_w-1:0] rd_m;
    logic [xlen-1:0]       alu_result_m;
    logic [xlen-1:0]       store_data_m;
    logic [xlen-1:0]       load_data_m;
    logic reg_wr_en_m, mem_read_m, mem_write_m;
    logic [xlen-1:0]       pc_w;
    logic [reg_addr_w-1:0] rd_w;
    logic [xlen-1:0]       alu_result_w;
    logic [xlen-1:0]       load_data_w;
    logic [xlen-1:0]       result_w;
    logic reg_wr_en_w, mem_read_w;

    fwd_sel_e forward_a_e;
    fwd_sel_e forward_b_e;
    logic     stall;
    logic     flush;

    // program is loaded only while the core is held in reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign instr_f = imem[pc_f[imem_addr_w+1:2]];

    // pc is 0 through reset, so the first clock after release fetches word 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_f <= '0;
        end else if (flush) begin
            pc_f <= ctrl_target_e;
        end else if (!stall) begin
            pc_f <= pc_f + xlen'(4);
        end
    end

    // fetch/decode register, held on stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush) begin
            instr_d <= nop_instr;
        end else if (!stall) begin
            instr_d <= instr_f;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            pc_d <= pc_f;
        end
    end

    decode_unit decode0 (
        .instr_i       (instr_d),
        .rs1_o         (rs1_d),
        .rs2_o         (rs2_d),
        .rd_o          (rd_d),
        .imm_o         (imm_d),
        .alu_op_o      (alu_sel_d),
        .alu_src_imm_o (alu_src_imm_d),
        .reg_wr_en_o   (reg_wr_en_d),
        .mem_read_o    (mem_read_d),
        .mem_write_o   (mem_write_d),
        .branch_o      (branch_d),
        .jump_o        (jump_d)
    );

    reg_file regs0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1_d),
        .rs2_i      (rs2_d),
        .wr_en_i    (reg_wr_en_w),
        .rd_i       (rd_w),
        .wr_data_i  (result_w),
        .rs1_data_o (rs1_data_d),
        .rs2_data_o (rs2_data_d)
    );

    // decode/execute control, a bubble on stall or flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush || stall) begin
            rs1_e         <= '0;
            rs2_e         <= '0;
            rd_e          <= '0;
            alu_sel_e     <= alu_add;
            alu_src_imm_e <= 1'b0;
            reg_wr_en_e   <= 1'b0;
            mem_read_e    <= 1'b0;
            mem_write_e   <= 1'b0;
            branch_e      <= 1'b0;
            jump_e        <= 1'b0;
        end else begin
            rs1_e         <= rs1_d;
            rs2_e         <= rs2_d;
            rd_e          <= rd_d;
            alu_sel_e     <= alu_sel_d;
            alu_src_imm_e <= alu_src_imm_d;
            reg_wr_en_e   <= reg_wr_en_d;
            mem_read_e    <= mem_read_d;
            mem_write_e   <= mem_write_d;
            branch_e      <= branch_d;
            jump_e        <= jump_d;
        end
    end

    // payload needs no clear, a bubble never uses it
    always_ff @(posedge clk_i) begin
        pc_e         <= pc_d;
        imm_e        <= imm_d;
        rs1_data_e   <= rs1_data_d;
        rs2_data_e   <= rs2_data_d;
        alu_result_m <= alu_result_e;
        store_data_m <= store_data_e;
        pc_m         <= pc_e;
        alu_result_w <= alu_result_m;
        load_data_w  <= load_data_m;
        pc_w         <= pc_m;
    end

    execute_stage execute0 (
        .pc_e_i          (pc_e),
        .rs1_data_e_i    (rs1_data_e),
        .rs2_data_e_i    (rs2_data_e),
        .imm_e_i         (imm_e),
        .alu_op_e_i      (alu_sel_e),
        .alu_src_imm_e_i (alu_src_imm_e),
        .branch_e_i      (branch_e),
        .jump_e_i        (jump_e),
        .forward_a_e_i   (forward_a_e),
        .forward_b_e_i   (forward_b_e),
        .alu_result_m_i  (alu_result_m),
        .result_w_i      (result_w),
        .alu_result_o    (alu_result_e),
        .store_data_o    (store_data_e),
        .ctrl_taken_o    (ctrl_taken_e),
        .ctrl_target_o   (ctrl_target_e)
    );

    hazard_unit hazard0 (
        .rs1_d_i        (rs1_d),
        .rs2_d_i        (rs2_d),
        .rs1_e_i        (rs1_e),
        .rs2_e_i        (rs2_e),
        .rd_e_i         (rd_e),
        .rd_m_i         (rd_m),
        .rd_w_i         (rd_w),
        .mem_read_e_i   (mem_read_e),
        .reg_wr_en_m_i  (reg_wr_en_m),
        .reg_wr_en_w_i  (reg_wr_en_w),
        .ctrl_taken_e_i (ctrl_taken_e),
        .forward_a_e_o  (forward_a_e),
        .forward_b_e_o  (forward_b_e),
        .stall_o        (stall),
        .flush_o        (flush)
    );

    // execute/memory and memory/writeback control
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_m        <= '0;
            reg_wr_en_m <= 1'b0;
            mem_read_m  <= 1'b0;
            mem_write_m <= 1'b0;
            rd_w        <= '0;
            reg_wr_en_w <= 1'b0;
            mem_read_w  <= 1'b0;
        end else begin
            rd_m        <= rd_e;
            reg_wr_en_m <= reg_wr_en_e;
            mem_read_m  <= mem_read_e;
            mem_write_m <= mem_write_e;
            rd_w        <= rd_m;
            reg_wr_en_w <= reg_wr_en_m;
            mem_read_w  <= mem_read_m;
        end
    end

    // data memory, word addressed by the alu result
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_write_m) begin
            dmem[alu_result_m[dmem_addr_w+1:2]] <= store_data_m;
        end
    end

    assign load_data_m = dmem[alu_result_m[dmem_addr_w+1:2]];

    assign result_w = mem_read_w ? load_data_w : alu_result_w;

    // bubbles carry rd x0, so only real register writes show up
    assign retire_valid_o = reg_wr_en_w && (rd_w != '0);
    assign retire_rd_o    = rd_w;
    assign retire_data_o  = result_w;
    assign retire_pc_o    = pc_w;

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // 8 ns period, low for the first half
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* tests/pipe_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_core_tb;
    import pipe_pkg::*;

    // quiet cycles watched after the last expected retire
    localparam int drain_cycles = 16;

    logic                   clk;
    logic                   rst_n;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   retire_valid;
    logic [reg_addr_w-1:0]  retire_rd;
    logic [xlen-1:0]        retire_data;
    logic [xlen-1:0]        retire_pc;

    // program image and expected trace from the tests file
    logic [imem_addr_w-1:0] prog_addr [$];
    logic [xlen-1:0]        prog_word [$];
    logic [reg_addr_w-1:0]  exp_rd [$];
    logic [xlen-1:0]        exp_data [$];

    // word image of the program, zero words never write a register
    logic [xlen-1:0]        prog_image [imem_depth];

    int value_errors;
    int other_errors;

    tb_clock clock0 (
        .clk_o (clk)
    );

    pipe_core dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .imem_we_i      (imem_we),
        .imem_addr_i    (imem_addr),
        .imem_wdata_i   (imem_wdata),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .retire_pc_o    (retire_pc)
    );

    // I lines hold program words, E lines hold expected retires
    task automatic read_tests();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  kind;
        logic [31:0] col_a;
        logic [31:0] col_b;
        foreach (prog_image[i]) begin
            prog_image[i] = '0;
        end
        fd = $fopen("tests/pipe_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/pipe_tests.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip blank and comment lines
            if (code > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%c %h %h", kind, col_a, col_b);
                if (code == 3 && kind == "I") begin
                    prog_addr.push_back(col_a[imem_addr_w-1:0]);
                    prog_word.push_back(col_b);
                    prog_image[col_a[imem_addr_w-1:0]] = col_b;
                end else if (code == 3 && kind == "E") begin
                    exp_rd.push_back(col_a[reg_addr_w-1:0]);
                    exp_data.push_back(col_b);
                end else begin
                    $display("malformed line in tests file: %s", line);
                    other_errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // next word at or after from that writes rd, -1 if there is none
    function automatic int find_writer(int from, logic [reg_addr_w-1:0] rd);
        logic [xlen-1:0] word;
        for (int i = from; i < imem_depth; i++) begin
            word = prog_image[i];
            // register ops, addi, lw and jal are the writers of the subset
            if ((word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011
                 || word[6:0] == 7'b0000011 || word[6:0] == 7'b1101111)
                && word[11:7] == rd) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_rd(input logic [reg_addr_w-1:0] expected,
                            input logic [reg_addr_w-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] retire_rd_o expected 0x%h got 0x%h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_data(input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] retire_data_o expected 0x%h got 0x%h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_pc(input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] retire_pc_o expected 0x%h got 0x%h", expected, actual);
            value_errors++;
        end
    endtask

    // one word per falling edge while reset is low, at least 3 reset cycles
    task automatic load_program();
        int held;
        held = 0;
        foreach (prog_word[i]) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = prog_addr[i];
            imem_wdata = prog_word[i];
            held++;
        end
        @(negedge clk);
        imem_we = 1'b0;
        held++;
        while (held < 3) begin
            @(negedge clk);
            held++;
        end
    endtask

    initial begin
        int limit;
        int cycles;
        int drained;
        int seen;
        int idx;
        int search_from;
        bit timed_out;
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        value_errors = 0;
        other_errors = 0;
        read_tests();
        if (exp_rd.size() == 0) begin
            $display("tests file holds no expected retires");
            other_errors++;
        end
        // bound scales with the program and trace length
        limit = 4 * (prog_word.size() + exp_rd.size()) + 50;
        load_program();
        rst_n       = 1'b1;
        cycles      = 0;
        drained     = 0;
        seen        = 0;
        search_from = 0;
        timed_out   = 1'b0;
        // retire outputs settle after the rising edge, sample them mid-cycle
        while (drained < drain_cycles && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (retire_valid === 1'b1) begin
                if (seen < exp_rd.size()) begin
                    check_rd(exp_rd[seen], retire_rd);
                    check_data(exp_data[seen], retire_data);
                    // flushed words are skipped, so the retiree is the next writer of rd
                    idx = find_writer(search_from, exp_rd[seen]);
                    if (idx < 0) begin
                        $display("no program word from index %0d writes x%0d", search_from,
                                 exp_rd[seen]);
                        other_errors++;
                    end else begin
                        check_pc(xlen'(idx * 4), retire_pc);
                        search_from = idx + 1;
                    end
                    seen++;
                end else begin
                    $display("unexpected extra retire of x%0d at pc 0x%h", retire_rd, retire_pc);
                    other_errors++;
                end
            end
            if (seen == exp_rd.size()) begin
                drained++;
            end else if (cycles >= limit) begin
                $display("timeout waiting for retire %0d of %0d", seen + 1, exp_rd.size());
                other_errors++;
                timed_out = 1'b1;
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/pipe_tests.txt */
# I <word index hex> <instruction hex>   program word for the load port
# E <rd hex> <value hex>                 expected retire, in program order
I 00 00500093  addi x1, x0, 5
I 01 00C00113  addi x2, x0, 12
I 02 FFD00193  addi x3, x0, -3
I 03 06400213  addi x4, x0, 100
I 04 002082B3  add  x5, x1, x2
I 05 40308333  sub  x6, x1, x3
I 06 004173B3  and  x7, x2, x4
I 07 00416433  or   x8, x2, x4
I 08 0020C4B3  xor  x9, x1, x2
I 09 0011A533  slt  x10, x3, x1
I 0A 00700593  addi x11, x0, 7
I 0B 00B585B3  add  x11, x11, x11   memory stage forward on both sources
I 0C 00158633  add  x12, x11, x1    x11 in memory and writeback, memory wins
I 0D 40B606B3  sub  x13, x12, x11   memory and writeback forward
I 0E 00C02423  sw   x12, 8(x0)      store data from writeback
I 0F 00802703  lw   x14, 8(x0)
I 10 00D707B3  add  x15, x14, x13   load-use stall
I 11 00668463  beq  x13, x6, +8     not taken
I 12 00100813  addi x16, x0, 1
I 13 00E60663  beq  x12, x14, +12   taken to word 16
I 14 00200893  addi x17, x0, 2      flushed
I 15 00300913  addi x18, x0, 3      flushed
I 16 00C009EF  jal  x19, +12        link 0x5c, to word 19
I 17 00400893  addi x17, x0, 4      flushed
I 18 00500913  addi x18, x0, 5      flushed
I 19 00900013  addi x0, x0, 9       never retires
I 1A 00100A33  add  x20, x0, x1
I 1B 00000AB3  add  x21, x0, x0
I 1C 0000006F  jal  x0, 0           parks the core
E 01 00000005
E 02 0000000C
E 03 FFFFFFFD
E 04 00000064
E 05 00000011
E 06 00000008
E 07 00000004
E 08 0000006C
E 09 00000009
E 0A 00000001
E 0B 00000007
E 0B 0000000E
E 0C 00000013
E 0D 00000005
E 0E 00000013
E 0F 00000018
E 10 00000001
E 13 0000005C
E 14 00000005
E 15 00000000

/* verilog.f */
common/pipe_pkg.sv
source/hazard_unit.sv
core/decode_unit.sv
core/reg_file.sv
core/execute_stage.sv
core/pipe_core.sv
tests/tb_clock.sv
tests/pipe_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module pipe_core_tb -o pipe_sim
out=$(./obj_dir/pipe_sim)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
